// ==== design/riscv_instr_pkg.sv ====
package riscv_instr_pkg;

  ////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////

  localparam int INSTR_W = 32;

  typedef logic [INSTR_W-1:0] instr_t;

  // Halfword walk states of the aligner
  typedef enum logic [1:0] {
    ALIGNED32,
    ALIGNED16,
    MISALIGNED32,
    MISALIGNED16
  } align_state_e;

  ////////////////////////////////////////
  // Base ISA opcodes
  ////////////////////////////////////////

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // funct3 of the expanded forms
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010;

  ////////////////////////////////////////
  // Compressed encoding
  ////////////////////////////////////////

  // Quadrant in bits [1:0]
  // 2'b11 marks a full-width instruction
  localparam logic [1:0] C_Q0         = 2'b00;
  localparam logic [1:0] C_Q1         = 2'b01;
  localparam logic [1:0] C_Q2         = 2'b10;
  localparam logic [1:0] C_FULL_WIDTH = 2'b11;

  // funct3 sits in bits [15:13]
  // Its meaning depends on the quadrant
  localparam logic [2:0] C3_ADDI   = 3'b000;
  localparam logic [2:0] C3_LI     = 3'b010;
  localparam logic [2:0] C3_J      = 3'b101;
  localparam logic [2:0] C3_LW     = 3'b010;
  localparam logic [2:0] C3_SW     = 3'b110;
  localparam logic [2:0] C3_MV_ADD = 3'b100;

  // Upper register bits of the 3-bit x8..x15 fields
  localparam logic [1:0] C_REG_PREFIX = 2'b01;

endpackage

// ==== design/fetch_cfg_pkg.sv ====
package fetch_cfg_pkg;

  ////////////////////////////////////////
  // Fetch buffer geometry
  ////////////////////////////////////////

  // Producer must never strobe more than this many unconsumed words
  localparam int FETCH_DEPTH = 4;
  localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////

  localparam int PC_W = 32;

  typedef logic [PC_W-1:0] pc_t;

endpackage

// ==== design/fetch_word_if.sv ====
`timescale 1ns/1ps

interface fetch_word_if;
  import riscv_instr_pkg::*;

  // Head of the fetch buffer
  logic   word_valid;
  instr_t word;
  // Consume head at the next edge
  logic   word_pop;
  // Restart request from the top level
  logic   flush;

  modport producer (
    output word_valid,
    output word,
    input  word_pop,
    input  flush
  );

  modport consumer (
    input  word_valid,
    input  word,
    output word_pop,
    input  flush
  );

endinterface

// ==== design/aligned_instr_if.sv ====
`timescale 1ns/1ps

interface aligned_instr_if;
  import riscv_instr_pkg::*;
  import fetch_cfg_pkg::*;

  // One strobe per instruction with no ready
  logic   valid;
  // Upper half is zero for compressed instructions
  instr_t instr;
  logic   compressed;
  pc_t    pc;

  modport producer (
    output valid,
    output instr,
    output compressed,
    output pc
  );

  modport consumer (
    input  valid,
    input  instr,
    input  compressed,
    input  pc
  );

endinterface

// ==== design/fetch_fifo.sv ====
`timescale 1ns/1ps

module fetch_fifo (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_valid_i,
  input  riscv_instr_pkg::instr_t  fetch_data_i,
  output logic                     overflow_o,
  fetch_word_if.producer           fw
);
  import riscv_instr_pkg::*;
  import fetch_cfg_pkg::*;

  // Word storage
  instr_t mem_q [FETCH_DEPTH];

  logic [FETCH_PTR_W-1:0] wr_ptr_q;
  logic [FETCH_PTR_W-1:0] rd_ptr_q;
  // One extra bit to tell full from empty
  logic [FETCH_PTR_W:0]   count_q;
  logic                   overflow_q;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (count_q == (FETCH_PTR_W+1)'(FETCH_DEPTH));
  assign empty = (count_q == '0);

  // Strobe into a full buffer is lost
  assign push = fetch_valid_i & ~full;
  // Pop only meaningful with a head present
  assign pop  = fw.word_pop & ~empty;

  ////////////////////////////////////////
  // Pointers, occupancy, overflow flag
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else if (fw.flush) begin
      // Everything pending is dropped on restart
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + (FETCH_PTR_W+1)'(1);
        2'b01:   count_q <= count_q - (FETCH_PTR_W+1)'(1);
        default: count_q <= count_q;
      endcase
      // Sticky until the next flush
      if (fetch_valid_i && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge clk) begin
    if (push && !fw.flush) begin
      mem_q[wr_ptr_q] <= fetch_data_i;
    end
  end

  // Head is visible the cycle after its strobe
  assign fw.word_valid = ~empty;
  assign fw.word       = mem_q[rd_ptr_q];
  assign overflow_o    = overflow_q;

endmodule

// ==== design/instr_aligner.sv ====
`timescale 1ns/1ps

module instr_aligner (
  input  logic                 clk,
  input  logic                 rst_n,
  input  fetch_cfg_pkg::pc_t   flush_pc_i,
  fetch_word_if.consumer       fw,
  aligned_instr_if.producer    ai
);
  import riscv_instr_pkg::*;
  import fetch_cfg_pkg::*;

  align_state_e state_q;
  align_state_e state_d;
  // Upper half of the last popped word
  logic [15:0]  residue_q;
  pc_t          pc_q;

  logic   emit;
  logic   pop;
  logic   out_compressed;
  instr_t out_instr;

  ////////////////////////////////////////
  // Next instruction selection
  ////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    emit           = 1'b0;
    pop            = 1'b0;
    out_compressed = 1'b0;
    out_instr      = '0;

    case (state_q)
      // Next instruction starts at the head word's low half
      ALIGNED32, MISALIGNED16: begin
        if (fw.word_valid) begin
          emit = 1'b1;
          pop  = 1'b1;
          if (fw.word[1:0] == C_FULL_WIDTH) begin
            // Whole word is one instruction
            out_instr = fw.word;
            state_d   = ALIGNED32;
          end else begin
            // Low half compressed and upper half kept as residue
            out_instr      = {16'b0, fw.word[15:0]};
            out_compressed = 1'b1;
            state_d        = ALIGNED16;
          end
        end
      end

      // Next instruction starts in the residue
      ALIGNED16, MISALIGNED32: begin
        if (residue_q[1:0] == C_FULL_WIDTH) begin
          // Straddling instruction needs the low half of the head
          if (fw.word_valid) begin
            emit      = 1'b1;
            pop       = 1'b1;
            out_instr = {fw.word[15:0], residue_q};
            state_d   = MISALIGNED32;
          end
        end else begin
          // Compressed residue goes out on its own while the head stays put
          emit           = 1'b1;
          out_instr      = {16'b0, residue_q};
          out_compressed = 1'b1;
          state_d        = MISALIGNED16;
        end
      end

      default: begin
        state_d = ALIGNED32;
      end
    endcase
  end

  ////////////////////////////////////////
  // State, residue and PC
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= ALIGNED32;
      residue_q <= '0;
      pc_q      <= '0;
    end else if (fw.flush) begin
      // Restart at a word-aligned target
      state_q   <= ALIGNED32;
      residue_q <= '0;
      pc_q      <= flush_pc_i;
    end else if (emit) begin
      state_q <= state_d;
      pc_q    <= out_compressed ? pc_q + PC_W'(2) : pc_q + PC_W'(4);
      // Every pop leaves the popped word's upper half behind
      if (pop) begin
        residue_q <= fw.word[31:16];
      end
    end
  end

  // Nothing leaves or is consumed in a flush cycle
  assign fw.word_pop   = pop & ~fw.flush;
  assign ai.valid      = emit & ~fw.flush;
  assign ai.instr      = out_instr;
  assign ai.compressed = out_compressed;
  assign ai.pc         = pc_q;

endmodule

// ==== design/compressed_expander.sv ====
`timescale 1ns/1ps

module compressed_expander (
  input  logic                     clk,
  input  logic                     rst_n,
  aligned_instr_if.consumer        ai,
  output logic                     instr_valid_o,
  output riscv_instr_pkg::instr_t  instr_o,
  output fetch_cfg_pkg::pc_t       pc_o,
  output logic                     compressed_o,
  output logic                     illegal_o
);
  import riscv_instr_pkg::*;
  import fetch_cfg_pkg::*;

  // Raw compressed halfword and its fields
  logic [15:0] c;
  logic [2:0]  c_funct3;
  logic [1:0]  c_quad;

  instr_t exp_instr;
  logic   exp_illegal;

  logic   valid_q;
  instr_t instr_q;
  pc_t    pc_q;
  logic   compressed_q;
  logic   illegal_q;

  assign c        = ai.instr[15:0];
  assign c_funct3 = c[15:13];
  assign c_quad   = c[1:0];

  ////////////////////////////////////////
  // RVC expansion
  ////////////////////////////////////////

  always_comb begin
    // Full-width words and unknown forms pass unchanged
    exp_instr   = ai.instr;
    exp_illegal = 1'b0;

    if (ai.compressed) begin
      exp_illegal = 1'b1;
      case (c_quad)
        C_Q0: begin
          if (c_funct3 == C3_LW) begin
            // lw rd', uimm(rs1') with the offset scaled by 4
            exp_instr   = {5'b0, c[5], c[12:10], c[6], 2'b00,
                           C_REG_PREFIX, c[9:7], F3_WORD,
                           C_REG_PREFIX, c[4:2], OPC_LOAD};
            exp_illegal = 1'b0;
          end else if (c_funct3 == C3_SW) begin
            // sw rs2', uimm(rs1') with the immediate split S-type style
            exp_instr   = {5'b0, c[5], c[12],
                           C_REG_PREFIX, c[4:2], C_REG_PREFIX, c[9:7], F3_WORD,
                           c[11:10], c[6], 2'b00, OPC_STORE};
            exp_illegal = 1'b0;
          end
        end

        C_Q1: begin
          if (c_funct3 == C3_ADDI) begin
            // addi rd, rd, imm
            // rd of x0 gives the NOP
            exp_instr   = {{7{c[12]}}, c[6:2], c[11:7], F3_ADD, c[11:7], OPC_OP_IMM};
            exp_illegal = 1'b0;
          end else if (c_funct3 == C3_LI) begin
            // addi rd, x0, imm
            exp_instr   = {{7{c[12]}}, c[6:2], 5'd0, F3_ADD, c[11:7], OPC_OP_IMM};
            exp_illegal = 1'b0;
          end else if (c_funct3 == C3_J) begin
            // jal x0, offset
            // Offset bits are scrambled as [11|4|9:8|10|6|7|3:1|5]
            exp_instr   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                           c[12], {8{c[12]}}, 5'd0, OPC_JAL};
            exp_illegal = 1'b0;
          end
        end

        C_Q2: begin
          // rs2 of x0 belongs to C.JR and C.JALR which are not covered here
          if (c_funct3 == C3_MV_ADD && c[6:2] != 5'd0) begin
            if (c[12]) begin
              // add rd, rd, rs2
              exp_instr = {7'b0, c[6:2], c[11:7], F3_ADD, c[11:7], OPC_OP};
            end else begin
              // add rd, x0, rs2
              exp_instr = {7'b0, c[6:2], 5'd0, F3_ADD, c[11:7], OPC_OP};
            end
            exp_illegal = 1'b0;
          end
        end

        default: begin
          exp_illegal = 1'b1;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  // Aligner holds valid low in a flush cycle, so flush clears this too
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ai.valid;
    end
  end

  // Payload captured with each valid strobe
  always_ff @(posedge clk) begin
    if (ai.valid) begin
      instr_q      <= exp_instr;
      pc_q         <= ai.pc;
      compressed_q <= ai.compressed;
      illegal_q    <= exp_illegal;
    end
  end

  assign instr_valid_o = valid_q;
  assign instr_o       = instr_q;
  assign pc_o          = pc_q;
  assign compressed_o  = compressed_q;
  assign illegal_o     = illegal_q;

endmodule

// ==== design/fetch_align_top.sv ====
`timescale 1ns/1ps

module fetch_align_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // Fetch side with one word per strobe
  input  logic                     fetch_valid_i,
  input  riscv_instr_pkg::instr_t  fetch_data_i,
  // Restart
  input  logic                     flush_i,
  input  fetch_cfg_pkg::pc_t       flush_pc_i,
  // Decoded instruction stream
  output logic                     instr_valid_o,
  output riscv_instr_pkg::instr_t  instr_o,
  output fetch_cfg_pkg::pc_t       pc_o,
  output logic                     compressed_o,
  output logic                     illegal_o,
  output logic                     overflow_o
);

  ////////////////////////////////////////
  // Internal buses
  ////////////////////////////////////////

  fetch_word_if    fw_bus ();
  aligned_instr_if ai_bus ();

  // Flush reaches buffer and aligner through the word bus
  assign fw_bus.flush = flush_i;

  ////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////

  fetch_fifo u_fetch_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid_i (fetch_valid_i),
    .fetch_data_i  (fetch_data_i),
    .overflow_o    (overflow_o),
    .fw            (fw_bus.producer)
  );

  instr_aligner u_instr_aligner (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_pc_i (flush_pc_i),
    .fw         (fw_bus.consumer),
    .ai         (ai_bus.producer)
  );

  compressed_expander u_compressed_expander (
    .clk           (clk),
    .rst_n         (rst_n),
    .ai            (ai_bus.consumer),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .compressed_o  (compressed_o),
    .illegal_o     (illegal_o)
  );

endmodule

// ==== sim/tb_fetch_align.sv ====
`timescale 1ns/1ps

module tb_fetch_align;
  import riscv_instr_pkg::*;
  import fetch_cfg_pkg::*;

  // Cycles allowed for the last instructions to come out
  localparam int DRAIN_TIMEOUT = 200;

  // One line of the stimulus table
  typedef struct packed {
    logic   is_flush;
    logic   ovf;       // overflow_o just before a flush
    instr_t data;      // fetch word or flush target
    int     gap;       // idle cycles after the entry or -1 for 2..4 at random
  } stim_t;

  // One line of the expected output table
  typedef struct packed {
    pc_t    pc;
    instr_t instr;
    logic   comp;
    logic   ill;
  } expect_t;

  logic   clk;
  logic   rst_n;
  logic   fetch_valid_i;
  instr_t fetch_data_i;
  logic   flush_i;
  pc_t    flush_pc_i;
  logic   instr_valid_o;
  instr_t instr_o;
  pc_t    pc_o;
  logic   compressed_o;
  logic   illegal_o;
  logic   overflow_o;

  stim_t   stim_q[$];
  expect_t exp_q[$];

  // Stimulus side counters
  int errors;
  int checks;
  // Monitor side counters
  int exp_idx    = 0;
  int mon_errors = 0;
  int mon_checks = 0;

  fetch_align_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid_i (fetch_valid_i),
    .fetch_data_i  (fetch_data_i),
    .flush_i       (flush_i),
    .flush_pc_i    (flush_pc_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .compressed_o  (compressed_o),
    .illegal_o     (illegal_o),
    .overflow_o    (overflow_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////

  task automatic queue_word(input instr_t word, input int gap);
    stim_t s;
    s = '{is_flush: 1'b0, ovf: 1'b0, data: word, gap: gap};
    stim_q.push_back(s);
  endtask

  task automatic schedule_flush(input pc_t target, input logic ovf, input int gap);
    stim_t s;
    s = '{is_flush: 1'b1, ovf: ovf, data: target, gap: gap};
    stim_q.push_back(s);
  endtask

  task automatic expect_instr(input pc_t pc, input instr_t instr, input logic comp,
                              input logic ill);
    expect_t e;
    e = '{pc: pc, instr: instr, comp: comp, ill: ill};
    exp_q.push_back(e);
  endtask

  task automatic build_tables();
    int k;
    // Plain 32-bit run from pc 0
    queue_word(32'h0010_0093, -1);
    queue_word(32'h0020_0113, -1);
    queue_word(32'h0020_81b3, -1);
    expect_instr(32'h00, 32'h0010_0093, 1'b0, 1'b0);
    expect_instr(32'h04, 32'h0020_0113, 1'b0, 1'b0);
    expect_instr(32'h08, 32'h0020_81b3, 1'b0, 1'b0);
    // C.NOP and C.ADDI x1,5 share one word
    queue_word(32'h0095_0001, -1);
    // C.LI x10,-1 then addi x3,x0,3 straddling into the next word
    queue_word(32'h0193_557d, -1);
    // Straddle tail then C.J +8
    queue_word(32'ha021_0030, -1);
    // C.LW x9,4(x10) and C.SW x11,8(x12)
    queue_word(32'hc60c_4144, -1);
    // C.MV x5,x6 and C.ADD x5,x6
    queue_word(32'h929a_829a, -1);
    // C.LWSP is outside the subset and another straddle follows
    queue_word(32'h0213_4082, -1);
    queue_word(32'h0001_0040, -1);
    expect_instr(32'h0c, 32'h0000_0013, 1'b1, 1'b0);
    expect_instr(32'h0e, 32'h0050_8093, 1'b1, 1'b0);
    expect_instr(32'h10, 32'hfff0_0513, 1'b1, 1'b0);
    expect_instr(32'h12, 32'h0030_0193, 1'b0, 1'b0);
    expect_instr(32'h16, 32'h0080_006f, 1'b1, 1'b0);
    expect_instr(32'h18, 32'h0045_2483, 1'b1, 1'b0);
    expect_instr(32'h1a, 32'h00b6_2423, 1'b1, 1'b0);
    expect_instr(32'h1c, 32'h0060_02b3, 1'b1, 1'b0);
    expect_instr(32'h1e, 32'h0062_82b3, 1'b1, 1'b0);
    expect_instr(32'h20, 32'h0000_4082, 1'b1, 1'b1);
    expect_instr(32'h22, 32'h0040_0213, 1'b0, 1'b0);
    expect_instr(32'h26, 32'h0000_0013, 1'b1, 1'b0);
    // Leaves a full-width residue and then a word lost to the flush
    queue_word(32'h0193_0001, -1);
    queue_word(32'h0050_0293, 0);
    schedule_flush(32'h100, 1'b0, -1);
    queue_word(32'h0060_0313, -1);
    expect_instr(32'h28, 32'h0000_0013, 1'b1, 1'b0);
    expect_instr(32'h100, 32'h0060_0313, 1'b0, 1'b0);
    // Eight back-to-back C.NOP pairs overrun the four-entry buffer
    for (k = 0; k < 8; k++) begin
      queue_word(32'h0001_0001, 0);
    end
    schedule_flush(32'h200, 1'b1, -1);
    queue_word(32'h0070_0393, -1);
    // Only seven halves leave before the flush cycle
    for (k = 0; k < 7; k++) begin
      expect_instr(32'h104 + 32'(2 * k), 32'h0000_0013, 1'b1, 1'b0);
    end
    expect_instr(32'h200, 32'h0070_0393, 1'b0, 1'b0);
  endtask

  ////////////////////////////////////////
  // Stimulus loop
  ////////////////////////////////////////

  task automatic apply_stimulus();
    int gap;
    foreach (stim_q[i]) begin
      if (stim_q[i].is_flush) begin
        checks++;
        if (overflow_o !== stim_q[i].ovf) begin
          errors++;
          $display("FAIL t=%0t overflow_o expected %b got %b", $time, stim_q[i].ovf,
                   overflow_o);
        end
        flush_i    = 1'b1;
        flush_pc_i = stim_q[i].data;
      end else begin
        fetch_valid_i = 1'b1;
        fetch_data_i  = stim_q[i].data;
      end
      @(posedge clk);
      #1;
      fetch_valid_i = 1'b0;
      fetch_data_i  = '0;
      flush_i       = 1'b0;
      // Flush clears the sticky flag at the same edge
      if (stim_q[i].is_flush) begin
        checks++;
        if (overflow_o !== 1'b0) begin
          errors++;
          $display("FAIL t=%0t overflow_o expected 0 got %b", $time, overflow_o);
        end
      end
      gap = stim_q[i].gap;
      if (gap < 0) begin
        gap = 2 + int'($urandom % 3);
      end
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // Bounded wait for every expected instruction
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_idx < exp_q.size() && cycles < DRAIN_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_idx < exp_q.size()) begin
      errors++;
      $display("Timeout: only %0d of %0d instructions came out", exp_idx, exp_q.size());
    end
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  // Outputs settle after the rising edge and are sampled on the falling one
  always @(negedge clk) begin
    if (rst_n === 1'b1 && instr_valid_o === 1'b1) begin
      if (exp_idx >= exp_q.size()) begin
        mon_errors++;
        $display("Unexpected instruction %h at pc %h, t=%0t", instr_o, pc_o, $time);
      end else begin
        mon_checks++;
        if (pc_o !== exp_q[exp_idx].pc) begin
          mon_errors++;
          $display("FAIL t=%0t pc_o expected %h got %h", $time, exp_q[exp_idx].pc, pc_o);
        end
        if (instr_o !== exp_q[exp_idx].instr) begin
          mon_errors++;
          $display("FAIL t=%0t instr_o expected %h got %h", $time, exp_q[exp_idx].instr,
                   instr_o);
        end
        if (compressed_o !== exp_q[exp_idx].comp) begin
          mon_errors++;
          $display("FAIL t=%0t compressed_o expected %b got %b", $time,
                   exp_q[exp_idx].comp, compressed_o);
        end
        if (illegal_o !== exp_q[exp_idx].ill) begin
          mon_errors++;
          $display("FAIL t=%0t illegal_o expected %b got %b", $time, exp_q[exp_idx].ill,
                   illegal_o);
        end
        exp_idx++;
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h2dac));
    errors        = 0;
    checks        = 0;
    rst_n         = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_data_i  = '0;
    flush_i       = 1'b0;
    flush_pc_i    = '0;
    build_tables();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Quiet outputs between reset and the first fetch
    repeat (3) begin
      @(posedge clk);
      #1;
      checks++;
      if (instr_valid_o !== 1'b0) begin
        errors++;
        $display("FAIL t=%0t instr_valid_o expected 0 got %b", $time, instr_valid_o);
      end
      if (overflow_o !== 1'b0) begin
        errors++;
        $display("FAIL t=%0t overflow_o expected 0 got %b", $time, overflow_o);
      end
    end
    apply_stimulus();
    wait_drain();
    // Idle tail so stray outputs still reach the monitor
    repeat (10) @(posedge clk);
    $display("Done: %0d checks, %0d errors", checks + mon_checks, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
design/riscv_instr_pkg.sv
design/fetch_cfg_pkg.sv
design/fetch_word_if.sv
design/aligned_instr_if.sv
design/fetch_fifo.sv
design/instr_aligner.sv
design/compressed_expander.sv
design/fetch_align_top.sv
sim/tb_fetch_align.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_align
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
